// ==== logic/apu_params.svh ====
`ifndef APU_PARAMS_SVH
`define APU_PARAMS_SVH

// Register file and program store
`define APU_NREGS       16
`define APU_PMEM_DEPTH  64
`define APU_PC_W        6

// Host address map, pmem lives where bit 7 is clear
`define APU_ADDR_CTRL   8'h80
`define APU_ADDR_STAT   8'h81
`define APU_ADDR_REGS   4'hC  // Upper nibble of 0xC0..0xCF

`endif

// ==== logic/apu_isa_pkg.sv ====
`default_nettype none

package apu_isa_pkg;

	// ALU function codes, grouped by the upper two bits
	typedef enum logic [3:0] {
		LOAD = 4'h0,
		AND  = 4'h1,
		OR   = 4'h2,
		XOR  = 4'h3,
		ADD  = 4'h4,
		ADC  = 4'h5,
		SUB  = 4'h6,
		SBC  = 4'h7,
		RR   = 4'h8,
		RRC  = 4'h9,
		SRA  = 4'hA,
		SRZ  = 4'hB,
		RL   = 4'hC,
		RLC  = 4'hD,
		MUL  = 4'hE,
		MULS = 4'hF
	} alu_func_e;

	typedef enum logic [1:0] {
		S8  = 2'b00,
		S16 = 2'b01,
		S24 = 2'b10,
		S32 = 2'b11
	} op_size_e;

	typedef struct packed {
		logic z;
		logic s;
		logic c;
		logic v;  // Always zero
	} apu_flags_t;

	typedef struct packed {
		logic        halt;
		logic        imm_form;
		alu_func_e   func;
		op_size_e    sz;
		logic [3:0]  dst;
		logic [3:0]  srca;
		logic [3:0]  srcb;
		logic [11:0] spare;
	} instr_r_t;

	// Same head as register form, srcb and spare replaced by imm
	typedef struct packed {
		logic        halt;
		logic        imm_form;
		alu_func_e   func;
		op_size_e    sz;
		logic [3:0]  dst;
		logic [3:0]  srca;
		logic [15:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

`default_nettype wire

// ==== logic/apu_host_pkg.sv ====
`default_nettype none
`include "apu_params.svh"

package apu_host_pkg;

	import apu_isa_pkg::*;

	// One host access, wr or rd held for a single cycle
	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} host_req_t;

	// Status word as read back at the STAT address
	typedef struct packed {
		logic                 busy;
		apu_flags_t           flags;
		logic [`APU_PC_W-1:0] pc;
	} apu_status_t;

	typedef enum logic [1:0] {
		PMEM = 2'd0,
		CTRL = 2'd1,
		STAT = 2'd2,
		REGS = 2'd3
	} host_region_e;

endpackage

`default_nettype wire

// ==== logic/apu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_alu
	import apu_isa_pkg::*;
(
	input  wire [31:0]      src,
	input  wire [31:0]      arg,
	input  wire             c,
	input  wire alu_func_e  func,
	input  wire op_size_e   sz,
	output logic [31:0]     res,
	output apu_flags_t      flags
);

	logic [31:0] src_m;
	logic [31:0] arg_m;
	logic [31:0] r_add;
	logic [31:0] r_sub;
	logic [31:0] r_as;
	logic [31:0] r_rr;
	logic [31:0] r_rl;
	logic [31:0] r_mul;
	logic [15:0] mul_a;
	logic [15:0] mul_b;
	logic        ca;
	logic        cs;
	logic        cin;
	logic        sub_op;
	logic        c_as;
	logic        top_bit;
	logic        lc;
	logic        rc;

	// Operands masked to the size, plus the size MSB of src
	always_comb begin
		case (sz)
			S8: begin
				src_m   = {24'h000000, src[7:0]};
				arg_m   = {24'h000000, arg[7:0]};
				top_bit = src[7];
			end
			S16: begin
				src_m   = {16'h0000, src[15:0]};
				arg_m   = {16'h0000, arg[15:0]};
				top_bit = src[15];
			end
			S24: begin
				src_m   = {8'h00, src[23:0]};
				arg_m   = {8'h00, arg[23:0]};
				top_bit = src[23];
			end
			default: begin
				src_m   = src;
				arg_m   = arg;
				top_bit = src[31];
			end
		endcase
	end

	assign cin    = c && (func == ADC || func == SBC);
	assign sub_op = (func == SUB || func == SBC);

	assign {ca, r_add} = {1'b0, src_m} + {1'b0, arg_m} + {32'h0, cin};
	assign {cs, r_sub} = {1'b0, src_m} - {1'b0, arg_m} - {32'h0, cin};
	assign r_as = sub_op ? r_sub : r_add;

	// Carry is the bit above the size, or the real carry-out at 32 bits
	always_comb begin
		case (sz)
			S8:      c_as = r_as[8];
			S16:     c_as = r_as[16];
			S24:     c_as = r_as[24];
			default: c_as = sub_op ? cs : ca;
		endcase
	end

	// Bit entering at the right shift boundary
	always_comb begin
		case (func)
			RR:      rc = src[0];
			RRC:     rc = c;
			SRA:     rc = top_bit;  // Sign copy
			default: rc = 1'b0;
		endcase
	end

	assign lc   = (func == RL) ? top_bit : c;
	assign r_rl = {src[30:0], lc};

	always_comb begin
		r_rr = {rc, src[31:1]};
		case (sz)
			S8:      r_rr[7]  = rc;
			S16:     r_rr[15] = rc;
			S24:     r_rr[23] = rc;
			default: r_rr[31] = rc;
		endcase
	end

	// 8x8, 8x8, 16x8, 16x16
	always_comb begin
		mul_a = (sz == S8 || sz == S16) ? {8'h00, src[7:0]} : src[15:0];
		mul_b = (sz == S32) ? arg[15:0] : {8'h00, arg[7:0]};
	end

	assign r_mul = {16'h0000, mul_a} * {16'h0000, mul_b};

	always_comb begin
		case (func)
			LOAD:              res = src;
			AND:               res = src & arg;
			OR:                res = src | arg;
			XOR:               res = src ^ arg;
			ADD, ADC, SUB, SBC: res = r_as;
			RR, RRC, SRA, SRZ: res = r_rr;
			RL, RLC:           res = r_rl;
			default:           res = r_mul;
		endcase
	end

	always_comb begin
		case (sz)
			S8: begin
				flags.z = (res[7:0] == 8'h00);
				flags.s = res[7];
			end
			S16: begin
				flags.z = (res[15:0] == 16'h0000);
				flags.s = res[15];
			end
			S24: begin
				flags.z = (res[23:0] == 24'h000000);
				flags.s = res[23];
			end
			default: begin
				flags.z = (res == 32'h0);
				flags.s = res[31];
			end
		endcase
		flags.v = 1'b0;
		case (func)
			LOAD, AND, OR, XOR: flags.c = 1'b0;
			ADD, ADC, SUB, SBC: flags.c = c_as;
			RR, RRC, SRA, SRZ:  flags.c = src[0];
			RL, RLC:            flags.c = top_bit;
			default:            flags.c = flags.s;  // MUL carry mirrors S
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/apu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apu_regfile (
	input  wire         clk,
	input  wire         rst_n,
	input  wire  [3:0]  ra,
	input  wire  [3:0]  rb,
	output logic [31:0] qa,
	output logic [31:0] qb,
	input  wire         we,
	input  wire  [3:0]  wa,
	input  wire  [31:0] wd,
	input  wire         hwe,
	input  wire  [3:0]  haddr,
	input  wire  [31:0] hwdata,
	output logic [31:0] hrdata
);

	logic [31:0] regs [`APU_NREGS];

	// Sequencer write first, host only gets the port when it is idle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `APU_NREGS; i++) begin
				regs[i] <= 32'h0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end else if (hwe) begin
			regs[haddr] <= hwdata;
		end
	end

	assign qa     = regs[ra];
	assign qb     = regs[rb];
	assign hrdata = regs[haddr];  // Registered later in ctrl_regs

endmodule

`default_nettype wire

// ==== logic/apu_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apu_ctrl_regs
	import apu_isa_pkg::*;
	import apu_host_pkg::*;
(
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire host_req_t           host,
	output logic [31:0]              rdata,
	input  wire  [`APU_PC_W-1:0]     fetch_pc,
	output instr_u                   instr,
	output logic                     go,
	output logic [`APU_PC_W-1:0]     entry_pc,
	input  wire apu_status_t         status,
	output logic                     hwe,
	output logic [3:0]               haddr,
	output logic [31:0]              hwdata,
	input  wire  [31:0]              hrdata
);

	logic [31:0]  pmem [`APU_PMEM_DEPTH];
	host_region_e region;
	logic         hit;
	logic         wr_ok;
	logic         pmem_we;
	logic         ctrl_we;
	logic [31:0]  rd_mux;

	// Address decode, gaps in the map give hit low
	always_comb begin
		hit    = 1'b1;
		region = PMEM;
		if (!host.addr[7])
			region = PMEM;
		else if (host.addr == `APU_ADDR_CTRL)
			region = CTRL;
		else if (host.addr == `APU_ADDR_STAT)
			region = STAT;
		else if (host.addr[7:4] == `APU_ADDR_REGS)
			region = REGS;
		else
			hit = 1'b0;
	end

	assign wr_ok   = host.wr && hit && !status.busy;  // Writes dropped while running
	assign pmem_we = wr_ok && (region == PMEM);
	assign ctrl_we = wr_ok && (region == CTRL) && !go;  // One start per idle period

	assign hwe    = wr_ok && (region == REGS);
	assign haddr  = host.addr[3:0];
	assign hwdata = host.wdata;

	// Program store with a registered fetch port
	always_ff @(posedge clk) begin
		if (pmem_we)
			pmem[host.addr[`APU_PC_W-1:0]] <= host.wdata;
		instr <= pmem[fetch_pc];
	end

	always_comb begin
		case (region)
			PMEM:    rd_mux = pmem[host.addr[`APU_PC_W-1:0]];
			CTRL:    rd_mux = {{(32 - `APU_PC_W){1'b0}}, entry_pc};
			STAT:    rd_mux = 32'(status);
			default: rd_mux = hrdata;
		endcase
		if (!hit)
			rd_mux = 32'h0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			go       <= 1'b0;
			entry_pc <= '0;
			rdata    <= 32'h0;
		end else begin
			go <= ctrl_we && host.wdata[31];
			if (ctrl_we)
				entry_pc <= host.wdata[`APU_PC_W-1:0];
			if (host.rd)
				rdata <= rd_mux;  // Holds until the next read
		end
	end

endmodule

`default_nettype wire

// ==== logic/apu_seq.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apu_seq
	import apu_isa_pkg::*;
	import apu_host_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   go,
	input  wire  [`APU_PC_W-1:0]  entry_pc,
	input  wire instr_u           instr,
	output logic [`APU_PC_W-1:0]  fetch_pc,
	output logic [3:0]            ra,
	output logic [3:0]            rb,
	input  wire  [31:0]           qa,
	input  wire  [31:0]           qb,
	output logic                  we,
	output logic [3:0]            wa,
	output logic [31:0]           wd,
	output apu_status_t           status,
	output logic                  done
);

	logic                 busy;
	logic                 exec_ph;  // Low in FETCH, high in EXEC
	logic [`APU_PC_W-1:0] pc;
	apu_flags_t           flags_q;
	apu_flags_t           alu_flags;
	logic [31:0]          alu_res;
	logic [31:0]          arg;
	logic                 in_exec;

	assign in_exec  = busy && exec_ph;
	assign fetch_pc = pc;

	// Operand select, srcb in register form and imm otherwise
	assign ra  = instr.r.srca;
	assign rb  = instr.r.srcb;
	assign arg = instr.r.imm_form ? {16'h0000, instr.i.imm} : qb;

	apu_alu u_alu (
		.src   (qa),
		.arg   (arg),
		.c     (flags_q.c),
		.func  (instr.r.func),
		.sz    (instr.r.sz),
		.res   (alu_res),
		.flags (alu_flags)
	);

	assign we   = in_exec && !instr.r.halt;
	assign wa   = instr.r.dst;
	assign wd   = alu_res;
	assign done = in_exec && instr.r.halt;

	always_comb begin
		status.busy  = busy;
		status.flags = flags_q;
		status.pc    = pc;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			exec_ph <= 1'b0;
			pc      <= '0;
			flags_q <= '0;
		end else if (!busy) begin
			if (go) begin
				busy    <= 1'b1;
				exec_ph <= 1'b0;
				pc      <= entry_pc;
			end
		end else if (!exec_ph) begin
			exec_ph <= 1'b1;  // Instruction word arrives this edge
		end else begin
			exec_ph <= 1'b0;
			if (instr.r.halt) begin
				busy <= 1'b0;  // pc stays on the halt word
			end else begin
				pc      <= pc + 1'b1;
				flags_q <= alu_flags;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/apu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apu_top
	import apu_isa_pkg::*;
	import apu_host_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	input  wire host_req_t    host,
	output logic [31:0]       rdata,
	output logic              busy,
	output logic              done
);

	logic [`APU_PC_W-1:0] fetch_pc;
	logic [`APU_PC_W-1:0] entry_pc;
	instr_u               instr;
	logic                 go;
	apu_status_t          status;

	// Host side of the register file
	logic                 hwe;
	logic [3:0]           haddr;
	logic [31:0]          hwdata;
	logic [31:0]          hrdata;

	// Sequencer side of the register file
	logic [3:0]           ra;
	logic [3:0]           rb;
	logic [31:0]          qa;
	logic [31:0]          qb;
	logic                 we;
	logic [3:0]           wa;
	logic [31:0]          wd;

	assign busy = status.busy;

	apu_ctrl_regs u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.host     (host),
		.rdata    (rdata),
		.fetch_pc (fetch_pc),
		.instr    (instr),
		.go       (go),
		.entry_pc (entry_pc),
		.status   (status),
		.hwe      (hwe),
		.haddr    (haddr),
		.hwdata   (hwdata),
		.hrdata   (hrdata)
	);

	apu_seq u_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.go       (go),
		.entry_pc (entry_pc),
		.instr    (instr),
		.fetch_pc (fetch_pc),
		.ra       (ra),
		.rb       (rb),
		.qa       (qa),
		.qb       (qb),
		.we       (we),
		.wa       (wa),
		.wd       (wd),
		.status   (status),
		.done     (done)
	);

	apu_regfile u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.ra     (ra),
		.rb     (rb),
		.qa     (qa),
		.qb     (qb),
		.we     (we),
		.wa     (wa),
		.wd     (wd),
		.hwe    (hwe),
		.haddr  (haddr),
		.hwdata (hwdata),
		.hrdata (hrdata)
	);

endmodule

`default_nettype wire

// ==== test/apu_tb_model.svh ====
`ifndef APU_TB_MODEL_SVH
`define APU_TB_MODEL_SVH

// Reference ALU: one function at one operand size
task automatic alu_reference(
	input  alu_func_e   f,
	input  op_size_e    sz,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic        cin,
	output logic [31:0] r,
	output apu_flags_t  fl
);
	int          n;
	logic [31:0] m;
	logic [32:0] w;
	logic [15:0] ma;
	logic [15:0] mb;
	logic        edge_in;

	n = 8 * (int'(sz) + 1);
	m = (n == 32) ? 32'hffff_ffff : ((32'h1 << n) - 32'h1);
	w = '0;
	edge_in = 1'b0;
	case (f)
		LOAD: r = a;
		AND:  r = a & b;
		OR:   r = a | b;
		XOR:  r = a ^ b;
		ADD, ADC: begin
			w = {1'b0, a & m} + {1'b0, b & m} + ((f == ADC) ? cin : 1'b0);
			r = w[31:0];
		end
		SUB, SBC: begin
			w = {1'b0, a & m} - {1'b0, b & m} - ((f == SBC) ? cin : 1'b0);
			r = w[31:0];
		end
		RR, RRC, SRA, SRZ: begin
			case (f)
				RR:      edge_in = a[0];
				RRC:     edge_in = cin;
				SRA:     edge_in = a[n-1];  // Sign of the sized operand
				default: edge_in = 1'b0;
			endcase
			r = {edge_in, a[31:1]};
			r[n-1] = edge_in;
		end
		RL, RLC: begin
			edge_in = (f == RL) ? a[n-1] : cin;
			r = {a[30:0], edge_in};
		end
		default: begin
			// Operand widths per size
			case (sz)
				S8, S16: begin
					ma = a[15:0] & 16'h00ff;
					mb = b[15:0] & 16'h00ff;
				end
				S24: begin
					ma = a[15:0];
					mb = b[15:0] & 16'h00ff;
				end
				default: begin
					ma = a[15:0];
					mb = b[15:0];
				end
			endcase
			r = ma * mb;
		end
	endcase
	fl.z = ((r & m) == 32'h0);
	fl.s = r[n-1];
	fl.v = 1'b0;
	case (f)
		LOAD, AND, OR, XOR: fl.c = 1'b0;
		ADD, ADC, SUB, SBC: fl.c = w[n];  // Bit above the size, carry-out at 32
		RR, RRC, SRA, SRZ:  fl.c = a[0];
		RL, RLC:            fl.c = a[n-1];
		default:            fl.c = fl.s;
	endcase
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic check_flags(input string name, input apu_flags_t got, input apu_flags_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic check_status(input string name, input apu_status_t got, input apu_status_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED %s: got %h, expected %h", name, got, exp);
	end
endtask

`endif

// ==== test/apu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "apu_params.svh"

module apu_tb
	import apu_isa_pkg::*;
	import apu_host_pkg::*;
();

	// About 7k+15 cycles per program of k instructions, plus margin
	localparam int LIMIT_CYCLES = (9 + 48 + 8) * (7 * 1 + 15) + 20 * (7 * 5 + 15)
		+ (7 * 6 + 15) + 300;

	logic        clk;
	logic        rst_n;
	host_req_t   host;
	logic [31:0] rdata;
	logic        busy;
	logic        done;

	integer      seed;
	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] shadow [16];  // Register file as the model sees it
	apu_flags_t  shadow_flags;
	logic [31:0] prog [$];     // Halt word is appended on load

	`include "apu_tb_model.svh"

	apu_top uut (
		.clk   (clk),
		.rst_n (rst_n),
		.host  (host),
		.rdata (rdata),
		.busy  (busy),
		.done  (done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT_CYCLES) begin
			$display("Run stopped by the cycle limit after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
		host_req_t req;
		req = '0;
		req.wr = 1'b1;
		req.addr = addr;
		req.wdata = data;
		@(posedge clk);
		host <= req;
		@(posedge clk);
		host <= '0;
	endtask

	// rdata is registered, valid the cycle after the strobe
	task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
		host_req_t req;
		req = '0;
		req.rd = 1'b1;
		req.addr = addr;
		@(posedge clk);
		host <= req;
		@(posedge clk);
		host <= '0;
		@(negedge clk);
		data = rdata;
	endtask

	task automatic set_reg(input logic [3:0] idx, input logic [31:0] val);
		write_word({`APU_ADDR_REGS, idx}, val);
		shadow[idx] = val;
	endtask

	function automatic logic [31:0] rform(alu_func_e f, op_size_e sz, logic [3:0] d,
		logic [3:0] a, logic [3:0] b);
		instr_u w;
		w = '0;
		w.r.func = f;
		w.r.sz = sz;
		w.r.dst = d;
		w.r.srca = a;
		w.r.srcb = b;
		return w;
	endfunction

	function automatic logic [31:0] iform(alu_func_e f, op_size_e sz, logic [3:0] d,
		logic [3:0] a, logic [15:0] imm);
		instr_u w;
		w = '0;
		w.i.imm_form = 1'b1;
		w.i.func = f;
		w.i.sz = sz;
		w.i.dst = d;
		w.i.srca = a;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] halt_word();
		instr_u w;
		w = '0;
		w.r.halt = 1'b1;
		return w;
	endfunction

	task automatic step_model(input instr_u w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		apu_flags_t  fl;
		a = shadow[w.r.srca];
		b = w.r.imm_form ? {16'h0000, w.i.imm} : shadow[w.r.srcb];
		alu_reference(w.r.func, w.r.sz, a, b, shadow_flags.c, r, fl);
		shadow[w.r.dst] = r;
		shadow_flags = fl;
	endtask

	task automatic load_prog();
		for (int i = 0; i < prog.size(); i++)
			write_word(8'(i), prog[i]);
		write_word(8'(prog.size()), halt_word());
	endtask

	task automatic start_prog();
		write_word(`APU_ADDR_CTRL, 32'h8000_0000);  // Entry at word 0
	endtask

	// Counts busy cycles up to and including the done cycle
	task automatic wait_done(input int k);
		int waited;
		int busy_cycles;
		bit seen;
		waited = 0;
		busy_cycles = 0;
		seen = 1'b0;
		while (!seen && waited < 2 * k + 40) begin
			@(negedge clk);
			waited++;
			if (busy)
				busy_cycles++;
			if (done)
				seen = 1'b1;
		end
		if (!seen) begin
			errors++;
			$display("done did not arrive within %0d cycles of the start", waited);
		end else begin
			check_word("done_cycles", busy_cycles, 2 * k + 2);
		end
		@(negedge clk);
		checks++;
		if (busy || done) begin
			errors++;
			$display("busy or done still high one cycle after done");
		end
	endtask

	task automatic compare_results();
		logic [31:0] got;
		apu_status_t st;
		instr_u      w;
		for (int i = 0; i < prog.size(); i++)
			step_model(prog[i]);
		for (int i = 0; i < prog.size(); i++) begin
			w = prog[i];
			read_word({`APU_ADDR_REGS, w.r.dst}, got);
			check_word($sformatf("r%0d", w.r.dst), got, shadow[w.r.dst]);
		end
		read_word(`APU_ADDR_STAT, got);
		st = got[$bits(apu_status_t)-1:0];
		check_flags("flags", st.flags, shadow_flags);
		check_word("pc", 32'(st.pc), prog.size());  // Stays on the halt word
	endtask

	task automatic run_prog();
		load_prog();
		start_prog();
		wait_done(prog.size());
		compare_results();
	endtask

	task automatic reset_values();
		logic [31:0] got;
		check_word("busy", busy, 32'h0);
		check_word("done", done, 32'h0);
		check_word("rdata", rdata, 32'h0);
		read_word(`APU_ADDR_STAT, got);
		check_status("status", got[$bits(apu_status_t)-1:0], '0);
	endtask

	task automatic logic_and_load();
		logic [31:0] ops [9];
		logic [15:0] imm;
		set_reg(1, $random(seed));
		set_reg(2, $random(seed));
		imm = $random(seed);
		ops[0] = rform(LOAD, S32, 3, 1, 0);
		ops[1] = rform(AND, S16, 4, 1, 2);
		ops[2] = rform(OR, S8, 5, 1, 2);
		ops[3] = rform(XOR, S24, 6, 1, 2);
		ops[4] = iform(AND, S32, 7, 1, imm);
		ops[5] = iform(OR, S8, 8, 2, imm);
		ops[6] = iform(XOR, S16, 9, 1, imm);
		ops[7] = iform(LOAD, S24, 10, 2, imm);
		ops[8] = iform(AND, S8, 11, 1, 16'h0000);  // Forces Z
		for (int i = 0; i < 9; i++) begin
			prog.delete();
			prog.push_back(ops[i]);
			run_prog();
		end
	endtask

	// ADC and SBC pick up the C left by the instruction before
	task automatic add_sub_chain();
		op_size_e sz;
		for (int i = 0; i < 20; i++) begin
			sz = op_size_e'(i % 4);
			set_reg(1, $random(seed));
			set_reg(2, $random(seed));
			prog.delete();
			prog.push_back(rform(ADD, sz, 3, 1, 2));
			prog.push_back(rform(ADC, sz, 4, 1, 2));
			prog.push_back(rform(SUB, sz, 5, 1, 2));
			prog.push_back(rform(SBC, sz, 6, 1, 2));
			prog.push_back(rform(ADC, sz, 7, 2, 1));
			run_prog();
		end
	endtask

	// One function per run so every C reaches the status word
	task automatic rotate_shift();
		op_size_e  sz;
		alu_func_e fn [6];
		fn = '{RR, RRC, SRA, SRZ, RL, RLC};
		for (int i = 0; i < 8; i++) begin
			sz = op_size_e'(i % 4);
			set_reg(1, $random(seed));
			for (int j = 0; j < 6; j++) begin
				prog.delete();
				prog.push_back(rform(fn[j], sz, 4'(3 + j), 1, 0));
				run_prog();  // RRC and RLC take the C of the run before
			end
		end
	endtask

	task automatic multiply();
		op_size_e sz;
		for (int i = 0; i < 4; i++) begin
			sz = op_size_e'(i);
			set_reg(1, $random(seed));
			set_reg(2, $random(seed));
			prog.delete();
			prog.push_back(rform(MUL, sz, 3, 1, 2));
			run_prog();
			prog.delete();
			prog.push_back(rform(MULS, sz, 4, 1, 2));
			run_prog();
		end
	endtask

	task automatic busy_protection();
		logic [31:0] got;
		logic        rerun;
		set_reg(1, $random(seed));
		set_reg(2, $random(seed));
		set_reg(9, $random(seed));
		prog.delete();
		prog.push_back(rform(LOAD, S32, 3, 1, 0));
		prog.push_back(rform(ADD, S32, 4, 3, 2));
		prog.push_back(rform(RL, S16, 5, 4, 0));
		prog.push_back(rform(MUL, S24, 6, 5, 2));
		prog.push_back(rform(SRA, S8, 7, 6, 0));
		prog.push_back(rform(XOR, S32, 8, 7, 1));
		load_prog();
		start_prog();
		fork
			wait_done(6);
			begin
				write_word(`APU_ADDR_CTRL, 32'h8000_0003);  // Second start while running
				write_word({`APU_ADDR_REGS, 4'd9}, ~shadow[9]);
				write_word(8'd2, 32'h0);
			end
		join
		rerun = 1'b0;
		repeat (8) begin
			@(negedge clk);
			if (busy)
				rerun = 1'b1;
		end
		checks++;
		if (rerun) begin
			errors++;
			$display("A start written while busy launched a second run");
		end
		compare_results();
		read_word(`APU_ADDR_CTRL, got);
		check_word("entry_pc", got, 32'h0);  // Still the entry of the first start
		read_word({`APU_ADDR_REGS, 4'd9}, got);
		check_word("r9", got, shadow[9]);
		read_word(8'd2, got);
		check_word("pmem[2]", got, prog[2]);
	endtask

	initial begin
		seed = 32'h47d49246;
		errors = 0;
		checks = 0;
		host = '0;
		rst_n = 1'b0;
		shadow_flags = '0;
		for (int i = 0; i < 16; i++)
			shadow[i] = 32'h0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		reset_values();
		logic_and_load();
		add_sub_chain();
		rotate_shift();
		multiply();
		busy_protection();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
+incdir+test
logic/apu_isa_pkg.sv
logic/apu_host_pkg.sv
logic/apu_alu.sv
logic/apu_regfile.sv
logic/apu_ctrl_regs.sv
logic/apu_seq.sv
logic/apu_top.sv
test/apu_tb.sv
